//--- Makefile
# Verilator build and run of the load-store unit testbench
VERILATOR ?= verilator
TOP       ?= lsu_tb
FLIST     ?= lsu_top.f
LOG       ?= sim.log
OBJ       ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)
	-./$(OBJ)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "No errors" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ) $(LOG)

//--- design/lsu_ctrl.sv
// request FSM for a single requester with at most one access outstanding
// req_i is a level and must stay stable until the grant
// a new request may be granted in the rvalid cycle of the previous one

module lsu_ctrl
(
  input  logic clk,
  input  logic rst_n,

  input  logic req_i,          // request level from mem stage
  input  logic data_gnt_i,
  input  logic data_rvalid_i,

  output logic data_req_o,
  output logic ready_mem_o,    // mem stage may advance
  output logic ready_wb_o,     // wb stage may advance
  output logic busy_o
);

  typedef enum logic {
    IDLE,                      // no access outstanding
    WAIT_RVALID                // granted, response pending
  } state_e;

  state_e state_q;
  state_e state_d;

  ////////////////////////////////////////
  // next state and bus request
  ////////////////////////////////////////

  always_comb
  begin
    state_d    = state_q;
    data_req_o = 1'b0;
    ready_wb_o = 1'b1;

    case (state_q)
      IDLE:
      begin
        data_req_o = req_i;    // straight through, same cycle
        if (req_i && data_gnt_i)
          state_d = WAIT_RVALID;
      end

      WAIT_RVALID:
      begin
        ready_wb_o = data_rvalid_i;  // low until the response lands
        if (data_rvalid_i)
        begin
          data_req_o = req_i;  // back-to-back issue in the rvalid cycle
          if (req_i && data_gnt_i)
            state_d = WAIT_RVALID;
          else
            state_d = IDLE;    // request, if any, stays up in idle
        end
      end

      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  // a pending request holds the mem stage until it is granted
  assign ready_mem_o = ~req_i | (data_req_o & data_gnt_i);

  assign busy_o = (state_q == WAIT_RVALID) | data_req_o;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  ////////////////////////////////////////
  // bus protocol
  ////////////////////////////////////////

  // the memory may only grant again once the old access has answered
  gnt_needs_rvalid_a: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == WAIT_RVALID && data_gnt_i) |-> data_rvalid_i)
    else $error("grant while waiting for rvalid of the previous access");

  no_rvalid_idle_a: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == IDLE) |-> !data_rvalid_i)
    else $error("rvalid with no access outstanding");

  req_known_a: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(req_i))
    else $error("request from mem stage is unknown");

endmodule

//--- design/lsu_load_align.sv
// load data extraction and extension, with the value held for writeback
// access attributes are captured at the grant and used at the rvalid
// a halfword at offset 3 has only its low byte in this word; the upper
// byte of the result is zero and sign extension takes that zero bit

module lsu_load_align
(
  input  logic                            clk,
  input  logic                            rst_n,

  input  logic                            gnt_i,
  input  logic                            rvalid_i,
  input  logic                            we_i,
  input  logic                            sign_ext_i,
  input  lsu_pkg::lsu_type_e              type_i,
  input  logic [lsu_pkg::OFS_W-1:0]       addr_offset_i,
  input  logic [lsu_pkg::DATA_W-1:0]      rdata_i,

  output logic [lsu_pkg::DATA_W-1:0]      rdata_wb_o
);

  lsu_pkg::lsu_type_e              type_q;
  logic [lsu_pkg::OFS_W-1:0]       offset_q;
  logic                            sign_ext_q;
  logic                            we_q;
  logic                            pend_q;      // a granted access awaits rvalid

  logic [lsu_pkg::DATA_W-1:0]      rdata_sh;    // addressed byte moved to lane 0
  logic [lsu_pkg::DATA_W-1:0]      rdata_ext;
  logic [lsu_pkg::DATA_W-1:0]      rdata_q;     // last load result

  ////////////////////////////////////////
  // attributes at grant
  ////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      type_q     <= lsu_pkg::LSU_WORD;
      offset_q   <= '0;
      sign_ext_q <= 1'b0;
      we_q       <= 1'b0;
      pend_q     <= 1'b0;
    end
    else
    begin
      if (gnt_i)
      begin
        type_q     <= type_i;
        offset_q   <= addr_offset_i;
        sign_ext_q <= sign_ext_i;
        we_q       <= we_i;
      end
      if (gnt_i)
        pend_q <= 1'b1;            // also covers a grant in the rvalid cycle
      else if (rvalid_i)
        pend_q <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // extraction and extension
  ////////////////////////////////////////

  assign rdata_sh = rdata_i >> {offset_q, 3'b000};  // zero fill from the top

  always_comb
  begin
    case (type_q)
      lsu_pkg::LSU_WORD: rdata_ext = rdata_i;
      lsu_pkg::LSU_HALF: rdata_ext = {{16{sign_ext_q & rdata_sh[15]}}, rdata_sh[15:0]};
      default:           rdata_ext = {{24{sign_ext_q & rdata_sh[7]}}, rdata_sh[7:0]};
    endcase
  end

  // held value only changes on a load response
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (rvalid_i && !we_q)
      rdata_q <= rdata_ext;
  end

  assign rdata_wb_o = (rvalid_i && !we_q) ? rdata_ext : rdata_q;

  // every response belongs to an earlier grant
  rvalid_after_gnt_a: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_i |-> pend_q)
    else $error("rvalid without a prior grant");

endmodule

//--- design/lsu_pkg.sv
// shared widths and encodings of the load-store unit
// lane logic elsewhere is written for a 32-bit word with four byte lanes only
// access type 2'b11 has no name of its own and decodes as a byte access

package lsu_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  localparam int ADDR_W = 32;  // byte address, one word
  localparam int DATA_W = 32;  // data word
  localparam int BE_W   = 4;   // byte lanes per word
  localparam int OFS_W  = 2;   // byte offset inside a word

  ////////////////////////////////////////
  // access type
  ////////////////////////////////////////

  // 00 word, 01 halfword, 10 and 11 byte
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

  ////////////////////////////////////////
  // bus constants
  ////////////////////////////////////////

  // byte enable patterns at offset 0, shifted up by the offset
  localparam logic [BE_W-1:0] BE_NONE = 4'b0000;  // no lane, never legal on the bus
  localparam logic [BE_W-1:0] BE_WORD = 4'b1111;
  localparam logic [BE_W-1:0] BE_HALF = 4'b0011;
  localparam logic [BE_W-1:0] BE_BYTE = 4'b0001;

  // last offset at which a halfword still fits in the word
  localparam logic [OFS_W-1:0] OFS_HALF_MAX = 2'b10;

endpackage

//--- design/lsu_store_align.sv
// byte enables, write data lanes and misaligned flag, all combinational
// a misaligned access is only flagged, its enables are clipped at lane 3
// and no second bus access is made for the remaining bytes

module lsu_store_align
(
  input  lsu_pkg::lsu_type_e              type_i,
  input  logic [lsu_pkg::OFS_W-1:0]       addr_offset_i,  // addr[1:0]
  input  logic                            req_i,
  input  logic [lsu_pkg::DATA_W-1:0]      wdata_i,

  output logic [lsu_pkg::BE_W-1:0]        be_o,
  output logic [lsu_pkg::DATA_W-1:0]      wdata_o,
  output logic                            misaligned_o
);

  ////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////

  // pattern shifted to the offset, upper lanes fall off the word
  always_comb
  begin
    case (type_i)
      lsu_pkg::LSU_WORD: be_o = lsu_pkg::BE_WORD << addr_offset_i;  // 1111 .. 1000
      lsu_pkg::LSU_HALF: be_o = lsu_pkg::BE_HALF << addr_offset_i;  // 0011 .. 1000
      default:           be_o = lsu_pkg::BE_BYTE << addr_offset_i;  // 10 and 11
    endcase
  end

  // every shifted pattern keeps at least its top lane
  always_comb
  begin
    be_not_empty_a: assert (be_o != lsu_pkg::BE_NONE)
      else $error("byte enables all zero");
  end

  ////////////////////////////////////////
  // write data
  ////////////////////////////////////////

  // rotate left by whole bytes, data byte 0 goes to lane offset
  always_comb
  begin
    case (addr_offset_i)
      2'b00:   wdata_o = wdata_i;
      2'b01:   wdata_o = {wdata_i[23:0], wdata_i[31:24]};
      2'b10:   wdata_o = {wdata_i[15:0], wdata_i[31:16]};
      default: wdata_o = {wdata_i[7:0],  wdata_i[31:8]};
    endcase
  end

  ////////////////////////////////////////
  // misaligned detection
  ////////////////////////////////////////

  always_comb
  begin
    misaligned_o = 1'b0;
    if (req_i)
    begin
      case (type_i)
        lsu_pkg::LSU_WORD: misaligned_o = (addr_offset_i != '0);
        lsu_pkg::LSU_HALF: misaligned_o = (addr_offset_i > lsu_pkg::OFS_HALF_MAX);
        default:           misaligned_o = 1'b0;  // a byte always fits
      endcase
    end
  end

endmodule

//--- design/lsu_top.sv
// load-store unit top, one request at a time on a req/gnt/rvalid bus
// address and write enable go to the bus unchanged, word aligned by the memory
// misaligned accesses are flagged only and never split

module lsu_top
(
  input  logic                            clk,
  input  logic                            rst_n,

  // mem stage
  input  logic                            req_i,
  input  logic                            we_i,
  input  lsu_pkg::lsu_type_e              type_i,
  input  logic [lsu_pkg::ADDR_W-1:0]      addr_i,
  input  logic [lsu_pkg::DATA_W-1:0]      wdata_i,
  input  logic                            sign_ext_i,
  output logic                            ready_mem_o,
  output logic                            misaligned_o,

  // wb stage
  output logic [lsu_pkg::DATA_W-1:0]      rdata_wb_o,
  output logic                            ready_wb_o,

  // data memory bus
  output logic                            data_req_o,
  output logic [lsu_pkg::ADDR_W-1:0]      data_addr_o,
  output logic                            data_we_o,
  output logic [lsu_pkg::BE_W-1:0]        data_be_o,
  output logic [lsu_pkg::DATA_W-1:0]      data_wdata_o,
  input  logic                            data_gnt_i,
  input  logic                            data_rvalid_i,
  input  logic                            data_err_i,
  input  logic [lsu_pkg::DATA_W-1:0]      data_rdata_i,

  // exceptions and status
  output logic                            load_err_o,
  output logic                            store_err_o,
  output logic                            busy_o
);

  logic [lsu_pkg::OFS_W-1:0] addr_offset;  // byte lane of the access

  assign addr_offset = addr_i[lsu_pkg::OFS_W-1:0];

  assign data_addr_o = addr_i;
  assign data_we_o   = we_i;

  // error is sampled with the grant, split by direction
  assign load_err_o  = data_gnt_i & data_err_i & ~we_i;
  assign store_err_o = data_gnt_i & data_err_i &  we_i;

  lsu_ctrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_req_o    (data_req_o),
    .ready_mem_o   (ready_mem_o),
    .ready_wb_o    (ready_wb_o),
    .busy_o        (busy_o)
  );

  lsu_store_align u_store_align (
    .type_i        (type_i),
    .addr_offset_i (addr_offset),
    .req_i         (req_i),
    .wdata_i       (wdata_i),
    .be_o          (data_be_o),
    .wdata_o       (data_wdata_o),
    .misaligned_o  (misaligned_o)
  );

  lsu_load_align u_load_align (
    .clk           (clk),
    .rst_n         (rst_n),
    .gnt_i         (data_gnt_i),
    .rvalid_i      (data_rvalid_i),
    .we_i          (we_i),
    .sign_ext_i    (sign_ext_i),
    .type_i        (type_i),
    .addr_offset_i (addr_offset),
    .rdata_i       (data_rdata_i),
    .rdata_wb_o    (rdata_wb_o)
  );

endmodule

//--- lsu_top.f
design/lsu_pkg.sv
design/lsu_ctrl.sv
design/lsu_store_align.sv
design/lsu_load_align.sv
design/lsu_top.sv
verification/lsu_tb.sv

//--- verification/lsu_tb.sv
// testbench for lsu_top, accesses and expected results come from the vector file
// the data memory is modelled here, grant delay 0..3 and rvalid delay 1..3 cycles
// every odd vector is issued and granted in the rvalid cycle of the one before
// the run stops at the first mismatch

module lsu_tb;

  localparam int MAX_VEC   = 64;
  localparam int BUSY_WAIT = 8;    // cycles allowed for busy_o to drop at the end
  localparam int SETTLE    = 2;    // sample point after the falling edge

  logic               clk = 1'b0;
  logic               rst_n;
  logic               req_i;
  logic               we_i;
  lsu_pkg::lsu_type_e type_i;
  logic [31:0]        addr_i;
  logic [31:0]        wdata_i;
  logic               sign_ext_i;
  logic               ready_mem_o;
  logic               misaligned_o;
  logic [31:0]        rdata_wb_o;
  logic               ready_wb_o;
  logic               data_req_o;
  logic [31:0]        data_addr_o;
  logic               data_we_o;
  logic [3:0]         data_be_o;
  logic [31:0]        data_wdata_o;
  logic               data_gnt_i;
  logic               data_rvalid_i;
  logic               data_err_i;
  logic [31:0]        data_rdata_i;
  logic               load_err_o;
  logic               store_err_o;
  logic               busy_o;

  // one entry per vector line
  string       v_name  [MAX_VEC];
  logic [31:0] v_we    [MAX_VEC];
  logic [31:0] v_type  [MAX_VEC];
  logic [31:0] v_sext  [MAX_VEC];
  logic [31:0] v_addr  [MAX_VEC];
  logic [31:0] v_wdata [MAX_VEC];
  logic [31:0] v_err   [MAX_VEC];   // error injected with the grant
  logic [31:0] v_be    [MAX_VEC];
  logic [31:0] v_mis   [MAX_VEC];
  logic [31:0] v_lerr  [MAX_VEC];
  logic [31:0] v_serr  [MAX_VEC];
  logic [31:0] v_rdata [MAX_VEC];   // load result, unused for stores
  int          n_vec;

  logic [31:0] mem [16];            // word index is addr[5:2]
  logic [31:0] rd_word;             // read data from grant to rvalid
  logic [31:0] last_load;           // value rdata_wb_o has to hold

  lsu_top dut_i (.*);

  always #10 clk = ~clk;

  ////////////////////////////////////////
  // reporting
  ////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_val(input string test, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else abort_run($sformatf("** Error %s: expected %h, actual %h", test, exp, act));
  endtask

  ////////////////////////////////////////
  // vectors and bus model
  ////////////////////////////////////////

  task automatic load_vectors();
    int    fd;
    int    cnt;
    string line;
    fd = $fopen("verification/lsu_vectors.txt", "r");
    if (fd == 0)
      abort_run("cannot open verification/lsu_vectors.txt");
    n_vec = 0;
    while ($fgets(line, fd) != 0)
    begin
      if (line.len() < 2 || line.getc(0) == "#")
        continue;                           // comment or blank line
      if (n_vec == MAX_VEC)
        abort_run("too many lines in the vector file");
      cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h", v_name[n_vec],
                    v_we[n_vec], v_type[n_vec], v_sext[n_vec], v_addr[n_vec],
                    v_wdata[n_vec], v_err[n_vec], v_be[n_vec], v_mis[n_vec],
                    v_lerr[n_vec], v_serr[n_vec], v_rdata[n_vec]);
      if (cnt != 12)
        abort_run({"malformed line in the vector file: ", line});
      n_vec++;
    end
    $fclose(fd);
    if (n_vec == 0)
      abort_run("the vector file holds no accesses");
  endtask

  task automatic drive_vec(input int k);
    req_i      = 1'b1;
    we_i       = v_we[k][0];
    type_i     = lsu_pkg::lsu_type_e'(v_type[k][1:0]);
    sign_ext_i = v_sext[k][0];
    addr_i     = v_addr[k];
    wdata_i    = v_wdata[k];
  endtask

  // grant cycle checks, then the memory accepts the access
  task automatic check_grant(input int k);
    logic [3:0] idx;
    int         lane;
    check_val({v_name[k], " req"},        32'd1,     32'(data_req_o));
    check_val({v_name[k], " we"},         v_we[k],   32'(data_we_o));
    check_val({v_name[k], " addr"},       v_addr[k], data_addr_o);
    check_val({v_name[k], " be"},         v_be[k],   32'(data_be_o));
    check_val({v_name[k], " misaligned"}, v_mis[k],  32'(misaligned_o));
    check_val({v_name[k], " load_err"},   v_lerr[k], 32'(load_err_o));
    check_val({v_name[k], " store_err"},  v_serr[k], 32'(store_err_o));
    check_val({v_name[k], " ready_mem"},  32'd1,     32'(ready_mem_o));
    check_val({v_name[k], " held rdata"}, last_load, rdata_wb_o);
    idx = data_addr_o[5:2];
    if (data_we_o && !data_err_i)         // an errored store is dropped
    begin
      for (lane = 0; lane < 4; lane++)
        if (data_be_o[lane])
          mem[idx][8*lane +: 8] = data_wdata_o[8*lane +: 8];
    end
    rd_word = mem[idx];                   // returned later with rvalid
  endtask

  task automatic issue_request(input int k);
    int delay;
    int w;
    delay = $urandom % 4;
    for (w = 0; w <= delay; w++)
    begin
      @(negedge clk);
      drive_vec(k);
      data_rvalid_i = 1'b0;
      data_gnt_i    = (w == delay);
      data_err_i    = (w == delay) ? v_err[k][0] : 1'b0;
      #SETTLE;
      if (w == delay)
        check_grant(k);
      else
      begin
        check_val({v_name[k], " req held"},   32'd1, 32'(data_req_o));
        check_val({v_name[k], " ready_mem"},  32'd0, 32'(ready_mem_o));
        check_val({v_name[k], " busy"},       32'd1, 32'(busy_o));
        check_val({v_name[k], " held rdata"}, last_load, rdata_wb_o);
      end
    end
  endtask

  // response of vector k, optionally granting k+1 in the rvalid cycle
  task automatic complete_access(input int k, input logic b2b);
    int delay;
    int w;
    delay = 1 + ($urandom % 3);
    for (w = 1; w <= delay; w++)
    begin
      @(negedge clk);
      req_i         = 1'b0;
      data_gnt_i    = 1'b0;
      data_err_i    = 1'b0;
      data_rvalid_i = (w == delay);
      data_rdata_i  = (w == delay) ? rd_word : $urandom;  // junk while not valid
      if (w == delay && b2b)
      begin
        drive_vec(k + 1);
        data_gnt_i = 1'b1;
        data_err_i = v_err[k + 1][0];
      end
      #SETTLE;
      if (w < delay)
      begin
        check_val({v_name[k], " ready_wb"},   32'd0, 32'(ready_wb_o));
        check_val({v_name[k], " busy"},       32'd1, 32'(busy_o));
        check_val({v_name[k], " mis no req"}, 32'd0, 32'(misaligned_o));
        check_val({v_name[k], " held rdata"}, last_load, rdata_wb_o);
      end
      else
      begin
        check_val({v_name[k], " ready_wb"}, 32'd1, 32'(ready_wb_o));
        if (!v_we[k][0])
          last_load = v_rdata[k];         // a store leaves the held value alone
        check_val({v_name[k], " rdata"}, last_load, rdata_wb_o);
        if (b2b)
          check_grant(k + 1);
      end
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial
  begin
    int   k;
    int   w;
    logic b2b;
    logic merged;
    void'($urandom(32'h527b));
    rst_n         = 1'b0;
    req_i         = 1'b0;
    we_i          = 1'b0;
    type_i        = lsu_pkg::LSU_WORD;
    addr_i        = '0;
    wdata_i       = '0;
    sign_ext_i    = 1'b0;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_err_i    = 1'b0;
    data_rdata_i  = '0;
    rd_word       = '0;
    last_load     = '0;
    for (k = 0; k < 16; k++)
      mem[k] = {4{~k[3:0], k[3:0]}};      // word 1 is e1e1e1e1
    load_vectors();

    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    #SETTLE;
    check_val("reset data_req",  32'd0, 32'(data_req_o));
    check_val("reset busy",      32'd0, 32'(busy_o));
    check_val("reset ready_mem", 32'd1, 32'(ready_mem_o));
    check_val("reset ready_wb",  32'd1, 32'(ready_wb_o));
    check_val("reset rdata_wb",  32'd0, rdata_wb_o);

    merged = 1'b0;
    for (k = 0; k < n_vec; k++)
    begin
      if (!merged)
        issue_request(k);
      b2b = (k + 1 < n_vec) && ((k + 1) % 2 == 1);
      complete_access(k, b2b);
      merged = b2b;
    end

    // no request follows the last response
    @(negedge clk);
    req_i         = 1'b0;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    #SETTLE;
    w = 0;
    while (busy_o)
    begin
      if (w == BUSY_WAIT)
        abort_run("busy_o stayed high after the last response");
      w++;
      @(negedge clk);
      #SETTLE;
    end
    check_val("end held rdata", last_load, rdata_wb_o);
    check_val("end ready_mem",  32'd1, 32'(ready_mem_o));
    check_val("end ready_wb",   32'd1, 32'(ready_wb_o));
    $display("No errors");
    $finish;
  end

endmodule

//--- verification/lsu_vectors.txt
# name we type sext addr wdata err, then expected be mis load_err store_err rdata, all hex
# type 0 word, 1 half, 2 and 3 byte; memory word i starts as {4{~i,i}} in nibbles
st_b0  1 2 0 00000000 000000aa 0 1 0 0 0 00000000
st_b1  1 2 0 00000001 000000bb 0 2 0 0 0 00000000
st_b2  1 2 0 00000002 000000cc 0 4 0 0 0 00000000
st_b3  1 3 0 00000003 000000dd 0 8 0 0 0 00000000
st_h0  1 1 0 00000004 00001234 0 3 0 0 0 00000000
st_h1  1 1 0 00000005 00005678 0 6 0 0 0 00000000
st_h2  1 1 0 00000006 00009abc 0 c 0 0 0 00000000
st_h3  1 1 0 00000007 0000ef01 0 8 1 0 0 00000000
st_w0  1 0 0 00000008 8765abcd 0 f 0 0 0 00000000
st_w1  1 0 0 0000000d 55667788 0 e 1 0 0 00000000
ld_w0  0 0 0 00000000 00000000 0 f 0 0 0 ddccbbaa
ld_w1  0 0 0 00000004 00000000 0 f 0 0 0 01bc7834
ld_w2  0 0 0 00000008 00000000 0 f 0 0 0 8765abcd
ld_w3  0 0 0 0000000c 00000000 0 f 0 0 0 667788c3
ld_wm  0 0 0 0000000d 00000000 0 e 1 0 0 667788c3
ld_b0u 0 2 0 00000000 00000000 0 1 0 0 0 000000aa
ld_b1s 0 2 1 00000001 00000000 0 2 0 0 0 ffffffbb
ld_b2u 0 2 0 00000002 00000000 0 4 0 0 0 000000cc
ld_b3s 0 3 1 00000003 00000000 0 8 0 0 0 ffffffdd
ld_b3p 0 2 1 00000007 00000000 0 8 0 0 0 00000001
ld_h0s 0 1 1 00000004 00000000 0 3 0 0 0 00007834
ld_h1s 0 1 1 00000005 00000000 0 6 0 0 0 ffffbc78
ld_h2u 0 1 0 00000006 00000000 0 c 0 0 0 000001bc
ld_h3s 0 1 1 00000007 00000000 0 8 1 0 0 00000001
ld_h2s 0 1 1 00000002 00000000 0 c 0 0 0 ffffddcc
ld_err 0 0 0 00000014 00000000 1 f 0 1 0 a5a5a5a5
st_err 1 0 0 00000018 12345678 1 f 0 0 1 00000000
